// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_rv_core
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_mem_port.sv
rv_core.sv
rv_core_props.sv
tb_axi_mem.sv
tb_rv_core.sv

// File: rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
	input wire clk,
	input wire rstn,
	input rv_pkg::alu_op_e op,
	input wire [rv_pkg::xlen-1:0] a,
	input wire [rv_pkg::xlen-1:0] b,
	output logic [rv_pkg::xlen-1:0] result
);

	logic [4:0] sh;
	logic lt_s;
	logic lt_u;
	logic [rv_pkg::xlen-1:0] y;

	assign sh = b[4:0];
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	always_comb begin
		case (op)
			rv_pkg::alu_add: y = a + b;
			rv_pkg::alu_sub: y = a - b;
			rv_pkg::alu_slt: y = {31'b0, lt_s};
			rv_pkg::alu_sltu: y = {31'b0, lt_u};
			rv_pkg::alu_xor: y = a ^ b;
			rv_pkg::alu_or: y = a | b;
			rv_pkg::alu_and: y = a & b;
			rv_pkg::alu_sll: y = a << sh;
			rv_pkg::alu_srl: y = a >> sh;
			rv_pkg::alu_sra: y = $unsigned($signed(a) >>> sh);
			rv_pkg::alu_eq: y = {31'b0, a == b};
			rv_pkg::alu_ne: y = {31'b0, a != b};
			rv_pkg::alu_lt: y = {31'b0, lt_s};
			rv_pkg::alu_ge: y = {31'b0, !lt_s};
			rv_pkg::alu_ltu: y = {31'b0, lt_u};
			default: y = {31'b0, !lt_u}; // geu
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			result <= '0;
		end else begin
			result <= y;
		end
	end

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
	input wire clk,
	input wire rstn,
	output rv_pkg::axi_req_t bus_req,
	input rv_pkg::axi_rsp_t bus_rsp
);

	rv_pkg::state_e state;
	logic [rv_pkg::xlen-1:0] pc;
	logic [rv_pkg::xlen-1:0] ir;
	rv_pkg::dec_t dec;

	logic [rv_pkg::xlen-1:0] rdata1;
	logic [rv_pkg::xlen-1:0] rdata2;
	logic [rv_pkg::xlen-1:0] alu_b;
	logic [rv_pkg::xlen-1:0] alu_result;

	logic mem_start;
	logic [1:0] mem_kind;
	logic [rv_pkg::xlen-1:0] mem_addr;
	logic [rv_pkg::xlen-1:0] store_data;
	logic mem_done;
	logic [rv_pkg::xlen-1:0] mem_rdata;

	logic [rv_pkg::xlen-1:0] ls_addr;
	logic [rv_pkg::xlen-1:0] pc_plus4;
	logic [rv_pkg::xlen-1:0] pc_imm;
	logic [rv_pkg::xlen-1:0] next_pc;
	logic [rv_pkg::xlen-1:0] wb_data;
	logic rf_we;
	logic is_mem_op;

	rv_decoder u_dec (
		.clk(clk),
		.instr(ir),
		.dec(dec)
	);

	rv_regfile u_rf (
		.clk(clk),
		.rstn(rstn),
		.rs1(ir[19:15]), // read during decode, ahead of dec
		.rs2(ir[24:20]),
		.rd(dec.rd),
		.we(rf_we),
		.wdata(wb_data),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	rv_alu u_alu (
		.clk(clk),
		.rstn(rstn),
		.op(dec.alu_op),
		.a(rdata1),
		.b(alu_b),
		.result(alu_result)
	);

	rv_mem_port u_mem (
		.clk(clk),
		.rstn(rstn),
		.start(mem_start),
		.kind(mem_kind),
		.size(dec.mem_size),
		.load_unsigned(dec.load_unsigned),
		.addr(mem_addr),
		.store_data(store_data),
		.done(mem_done),
		.rdata(mem_rdata),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp)
	);

	assign alu_b = dec.use_imm ? dec.imm : rdata2;
	assign ls_addr = rdata1 + dec.imm;
	assign pc_plus4 = pc + 32'd4;
	assign pc_imm = pc + dec.imm;
	assign is_mem_op = dec.is_load || dec.is_store;
	assign store_data = rdata2;

	assign mem_kind = (state == rv_pkg::st_fetch) ? rv_pkg::kind_fetch :
		dec.is_store ? rv_pkg::kind_store : rv_pkg::kind_load;
	assign mem_addr = (state == rv_pkg::st_fetch) ? pc : ls_addr;

	always_comb begin
		if (dec.is_lui) wb_data = dec.imm;
		else if (dec.is_auipc) wb_data = pc_imm;
		else if (dec.is_load) wb_data = mem_rdata;
		else if (dec.is_jal || dec.is_jalr) wb_data = pc_plus4; // link
		else wb_data = alu_result;
	end

	always_comb begin
		if (dec.is_jal) next_pc = pc_imm;
		else if (dec.is_jalr) next_pc = {ls_addr[31:1], 1'b0};
		else if (dec.is_branch && alu_result != '0) next_pc = pc_imm;
		else next_pc = pc_plus4;
	end

	assign rf_we = (state == rv_pkg::st_write) && dec.writes_rd;

	always_ff @(posedge clk) begin
		if (state == rv_pkg::st_fetch && mem_done) begin
			ir <= mem_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= rv_pkg::st_wait;
			pc <= rv_pkg::reset_pc;
			mem_start <= 1'b0;
		end else begin
			mem_start <= 1'b0;
			case (state)
				rv_pkg::st_wait: begin
					state <= rv_pkg::st_fetch;
					mem_start <= 1'b1;
				end
				rv_pkg::st_fetch: if (mem_done) state <= rv_pkg::st_decode;
				rv_pkg::st_decode: state <= rv_pkg::st_execute;
				rv_pkg::st_execute: begin
					state <= rv_pkg::st_mem;
					mem_start <= is_mem_op;
				end
				rv_pkg::st_mem: if (!is_mem_op || mem_done) state <= rv_pkg::st_write;
				default: begin // write
					pc <= next_pc;
					state <= rv_pkg::st_fetch;
					mem_start <= 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rv_core_props.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_props (
	input wire clk,
	input wire rstn,
	input rv_pkg::axi_req_t bus_req,
	input rv_pkg::axi_rsp_t bus_rsp
);

	int fails = 0;

	a_reset_idle: assert property (@(posedge clk) !rstn |=> !bus_req.arvalid &&
		!bus_req.rready && !bus_req.awvalid && !bus_req.wvalid && !bus_req.bready)
		else begin $error("bus outputs not idle after reset"); fails++; end

	a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		bus_req.arvalid && !bus_rsp.arready |=> bus_req.arvalid && $stable(bus_req.araddr))
		else begin $error("arvalid dropped or araddr moved before arready"); fails++; end

	a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
		bus_req.awvalid && !bus_rsp.awready |=> bus_req.awvalid && $stable(bus_req.awaddr))
		else begin $error("awvalid dropped or awaddr moved before awready"); fails++; end

	a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
		bus_req.wvalid && !bus_rsp.wready |=> bus_req.wvalid && $stable(bus_req.wdata))
		else begin $error("wvalid dropped or wdata moved before wready"); fails++; end

	a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
		bus_req.rready && !bus_rsp.rvalid |=> bus_req.rready)
		else begin $error("rready dropped before rvalid"); fails++; end

	// write response only once both aw and w are done
	a_b_order: assert property (@(posedge clk) disable iff (!rstn)
		bus_req.bready |-> !bus_req.awvalid && !bus_req.wvalid)
		else begin $error("bready raised while aw or w pending"); fails++; end

	a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
		bus_req.bready && !bus_rsp.bvalid |=> bus_req.bready)
		else begin $error("bready dropped before bvalid"); fails++; end

endmodule

`default_nettype wire

// File: rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
	input wire clk,
	input wire [rv_pkg::xlen-1:0] instr,
	output rv_pkg::dec_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [rv_pkg::xlen-1:0] imm_i;
	logic [rv_pkg::xlen-1:0] imm_s;
	logic [rv_pkg::xlen-1:0] imm_b;
	logic [rv_pkg::xlen-1:0] imm_u;
	logic [rv_pkg::xlen-1:0] imm_j;
	logic [rv_pkg::xlen-1:0] shamt;
	logic f7_plain;
	logic f7_alt;
	logic ok;
	rv_pkg::dec_t d;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign f7_plain = (funct7 == 7'b0000000);
	assign f7_alt = (funct7 == rv_pkg::funct7_alt);

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign shamt = {27'b0, instr[24:20]}; // zero-extended shift amount

	always_comb begin
		d = '0;
		ok = 1'b0;
		d.rd = instr[11:7];
		d.rs1 = instr[19:15];
		d.rs2 = instr[24:20];
		d.mem_size = rv_pkg::mem_word;
		case (opcode)
			rv_pkg::opc_lui: begin
				ok = 1'b1;
				d.is_lui = 1'b1;
				d.imm = imm_u;
			end
			rv_pkg::opc_auipc: begin
				ok = 1'b1;
				d.is_auipc = 1'b1;
				d.imm = imm_u;
			end
			rv_pkg::opc_jal: begin
				ok = 1'b1;
				d.is_jal = 1'b1;
				d.imm = imm_j;
			end
			rv_pkg::opc_jalr: begin
				ok = (funct3 == 3'b000);
				d.is_jalr = 1'b1;
				d.imm = imm_i;
			end
			rv_pkg::opc_branch: begin
				ok = (funct3[2:1] != 2'b01);
				d.is_branch = 1'b1;
				d.imm = imm_b;
				case (funct3)
					3'b000: d.alu_op = rv_pkg::alu_eq;
					3'b001: d.alu_op = rv_pkg::alu_ne;
					3'b100: d.alu_op = rv_pkg::alu_lt;
					3'b101: d.alu_op = rv_pkg::alu_ge;
					3'b110: d.alu_op = rv_pkg::alu_ltu;
					default: d.alu_op = rv_pkg::alu_geu;
				endcase
			end
			rv_pkg::opc_load: begin
				ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010) ||
					(funct3 == 3'b100) || (funct3 == 3'b101);
				d.is_load = 1'b1;
				d.imm = imm_i;
				d.mem_size = rv_pkg::mem_size_e'(funct3[1:0]);
				d.load_unsigned = funct3[2];
			end
			rv_pkg::opc_store: begin
				ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
				d.is_store = 1'b1;
				d.imm = imm_s;
				d.mem_size = rv_pkg::mem_size_e'(funct3[1:0]);
			end
			rv_pkg::opc_op_imm, rv_pkg::opc_op: begin
				d.use_imm = (opcode == rv_pkg::opc_op_imm);
				d.imm = imm_i;
				ok = f7_plain || d.use_imm; // op-imm has no funct7 except on shifts
				case (funct3)
					3'b000: begin
						d.alu_op = (!d.use_imm && f7_alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
						ok = d.use_imm || f7_plain || f7_alt;
					end
					3'b001: begin
						d.alu_op = rv_pkg::alu_sll;
						d.imm = shamt;
						ok = f7_plain;
					end
					3'b010: d.alu_op = rv_pkg::alu_slt;
					3'b011: d.alu_op = rv_pkg::alu_sltu;
					3'b100: d.alu_op = rv_pkg::alu_xor;
					3'b101: begin
						d.alu_op = f7_alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
						d.imm = shamt;
						ok = f7_plain || f7_alt;
					end
					3'b110: d.alu_op = rv_pkg::alu_or;
					default: d.alu_op = rv_pkg::alu_and;
				endcase
			end
			default: ok = 1'b0;
		endcase
		d.writes_rd = ok && !d.is_branch && !d.is_store;
		if (!ok) begin
			d = '0; // retires as a no-op
		end
	end

	always_ff @(posedge clk) begin
		dec <= d;
	end

endmodule

`default_nettype wire

// File: rv_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module rv_mem_port (
	input wire clk,
	input wire rstn,
	input wire start,
	input wire [1:0] kind,
	input rv_pkg::mem_size_e size,
	input wire load_unsigned,
	input wire [rv_pkg::xlen-1:0] addr,
	input wire [rv_pkg::xlen-1:0] store_data,
	output logic done,
	output logic [rv_pkg::xlen-1:0] rdata,
	output rv_pkg::axi_req_t bus_req,
	input rv_pkg::axi_rsp_t bus_rsp
);

	typedef enum logic [2:0] {ms_idle, ms_ar, ms_r, ms_w, ms_b} mstate_e;

	mstate_e ms;
	rv_pkg::axi_req_t req;
	logic [1:0] kind_q;
	rv_pkg::mem_size_e size_q;
	logic uns_q;
	logic [1:0] lane_q;
	logic [rv_pkg::xlen-1:0] wdata_fmt;
	logic [3:0] wstrb_fmt;
	logic [7:0] byte_sel;
	logic [15:0] half_sel;
	logic [rv_pkg::xlen-1:0] load_fmt;
	logic aw_ok;
	logic w_ok;

	assign bus_req = req;

	// store lane placement
	always_comb begin
		case (size)
			rv_pkg::mem_byte: begin
				wstrb_fmt = 4'b0001 << addr[1:0];
				wdata_fmt = {24'b0, store_data[7:0]} << {addr[1:0], 3'b000};
			end
			rv_pkg::mem_half: begin
				wstrb_fmt = addr[1] ? 4'b1100 : 4'b0011;
				wdata_fmt = addr[1] ? {store_data[15:0], 16'b0} : {16'b0, store_data[15:0]};
			end
			default: begin
				wstrb_fmt = 4'b1111;
				wdata_fmt = store_data;
			end
		endcase
	end

	// load lane extraction
	always_comb begin
		case (lane_q)
			2'd0: byte_sel = bus_rsp.rdata[7:0];
			2'd1: byte_sel = bus_rsp.rdata[15:8];
			2'd2: byte_sel = bus_rsp.rdata[23:16];
			default: byte_sel = bus_rsp.rdata[31:24];
		endcase
		half_sel = lane_q[1] ? bus_rsp.rdata[31:16] : bus_rsp.rdata[15:0];
		if (kind_q == rv_pkg::kind_fetch || size_q == rv_pkg::mem_word) begin
			load_fmt = bus_rsp.rdata;
		end else if (size_q == rv_pkg::mem_byte) begin
			load_fmt = {{24{byte_sel[7] & !uns_q}}, byte_sel};
		end else begin
			load_fmt = {{16{half_sel[15] & !uns_q}}, half_sel};
		end
	end

	assign aw_ok = !req.awvalid || bus_rsp.awready;
	assign w_ok = !req.wvalid || bus_rsp.wready;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ms <= ms_idle;
			done <= 1'b0;
			req.arvalid <= 1'b0;
			req.rready <= 1'b0;
			req.awvalid <= 1'b0;
			req.wvalid <= 1'b0;
			req.bready <= 1'b0;
		end else begin
			done <= 1'b0;
			case (ms)
				ms_idle: if (start) begin
					kind_q <= kind;
					size_q <= size;
					uns_q <= load_unsigned;
					lane_q <= addr[1:0];
					if (kind == rv_pkg::kind_store) begin
						req.awaddr <= {addr[31:2], 2'b00};
						req.wdata <= wdata_fmt;
						req.wstrb <= wstrb_fmt;
						req.awvalid <= 1'b1;
						req.wvalid <= 1'b1;
						ms <= ms_w;
					end else begin
						req.araddr <= {addr[31:2], 2'b00}; // word aligned
						req.arvalid <= 1'b1;
						ms <= ms_ar;
					end
				end
				ms_ar: if (bus_rsp.arready) begin
					req.arvalid <= 1'b0;
					req.rready <= 1'b1;
					ms <= ms_r;
				end
				ms_r: if (bus_rsp.rvalid) begin
					req.rready <= 1'b0;
					rdata <= load_fmt;
					done <= 1'b1;
					ms <= ms_idle;
				end
				ms_w: begin
					if (bus_rsp.awready) req.awvalid <= 1'b0;
					if (bus_rsp.wready) req.wvalid <= 1'b0;
					if (aw_ok && w_ok) begin
						req.bready <= 1'b1; // both channels accepted
						ms <= ms_b;
					end
				end
				default: if (bus_rsp.bvalid) begin
					req.bready <= 1'b0;
					done <= 1'b1;
					ms <= ms_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op = 7'b0110011;

	localparam logic [6:0] funct7_alt = 7'b0100000; // sub, sra

	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

	// memory port request kinds
	localparam logic [1:0] kind_fetch = 2'd0;
	localparam logic [1:0] kind_load = 2'd1;
	localparam logic [1:0] kind_store = 2'd2;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu,
		alu_xor, alu_or, alu_and, alu_sll,
		alu_srl, alu_sra, alu_eq, alu_ne,
		alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_e;

	typedef enum logic [1:0] {
		mem_byte, mem_half, mem_word
	} mem_size_e;

	typedef enum logic [2:0] {
		st_wait, st_fetch, st_decode, st_execute, st_mem, st_write
	} state_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [xlen-1:0] imm;
		logic use_imm;
		mem_size_e mem_size;
		logic is_lui;
		logic is_auipc;
		logic is_jal;
		logic is_jalr;
		logic is_branch;
		logic is_load;
		logic is_store;
		logic load_unsigned;
		logic writes_rd;
	} dec_t;

	typedef struct packed {
		logic [xlen-1:0] araddr;
		logic arvalid;
		logic rready;
		logic [xlen-1:0] awaddr;
		logic awvalid;
		logic [xlen-1:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
	} axi_req_t;

	typedef struct packed {
		logic arready;
		logic [xlen-1:0] rdata;
		logic rvalid;
		logic awready;
		logic wready;
		logic bvalid;
	} axi_rsp_t;

endpackage

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
	input wire clk,
	input wire rstn,
	input wire [rv_pkg::reg_addr_w-1:0] rs1,
	input wire [rv_pkg::reg_addr_w-1:0] rs2,
	input wire [rv_pkg::reg_addr_w-1:0] rd,
	input wire we,
	input wire [rv_pkg::xlen-1:0] wdata,
	output logic [rv_pkg::xlen-1:0] rdata1,
	output logic [rv_pkg::xlen-1:0] rdata2
);

	logic [rv_pkg::xlen-1:0] regs [1:31]; // x0 not stored

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		rdata1 <= (rs1 == '0) ? '0 : regs[rs1];
		rdata2 <= (rs2 == '0) ? '0 : regs[rs2];
	end

endmodule

`default_nettype wire

// File: tb_axi_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem (
	input wire clk,
	input wire rstn,
	input rv_pkg::axi_req_t req,
	output rv_pkg::axi_rsp_t rsp
);

	logic [31:0] words [0:2047];
	logic [31:0] wr_addr_q [$];
	logic [31:0] wr_data_q [$];
	logic [3:0] wr_strb_q [$];

	int seed = 88;
	int ar_cnt;
	int r_cnt;
	int aw_cnt;
	int w_cnt;
	int b_cnt;
	logic rd_pend;
	logic aw_got;
	logic w_got;
	logic [31:0] rd_addr;
	logic [31:0] wr_addr;
	logic [31:0] wr_data;
	logic [3:0] wr_strb;
	logic rstn_s;
	rv_pkg::axi_req_t req_s;
	rv_pkg::axi_rsp_t rsp_s;
	rv_pkg::axi_rsp_t rsp_r = '0;

	assign rsp = rsp_r;

	function automatic int draw_delay();
		return $unsigned($random(seed)) % 4; // 0..3 cycles
	endfunction

	task automatic fill_pattern();
		for (int i = 0; i < 2048; i++) begin
			words[i] = {16'hbad0, 3'b000, i[10:0], 2'b00};
		end
	endtask

	task automatic commit_write();
		for (int b = 0; b < 4; b++) begin
			if (wr_strb[b]) words[wr_addr[12:2]][8*b +: 8] = wr_data[8*b +: 8];
		end
		wr_addr_q.push_back(wr_addr);
		wr_data_q.push_back(wr_data);
		wr_strb_q.push_back(wr_strb);
	endtask

	always @(posedge clk) begin
		req_s = req; // sampled at the edge, driven 1 ns later
		rsp_s = rsp_r;
		rstn_s = rstn;
		#1;
		if (!rstn_s) begin
			rsp_r = '0;
			ar_cnt = 0;
			r_cnt = 0;
			aw_cnt = 0;
			w_cnt = 0;
			b_cnt = 0;
			rd_pend = 1'b0;
			aw_got = 1'b0;
			w_got = 1'b0;
		end else begin
			rsp_r.arready = 1'b0;
			rsp_r.awready = 1'b0;
			rsp_r.wready = 1'b0;
			if (rsp_s.arready && req_s.arvalid) begin
				rd_addr = req_s.araddr;
				rd_pend = 1'b1;
				r_cnt = draw_delay();
				ar_cnt = draw_delay();
			end else if (req_s.arvalid && !rd_pend && !rsp_s.rvalid) begin
				if (ar_cnt == 0) rsp_r.arready = 1'b1;
				else ar_cnt--;
			end
			if (rsp_s.rvalid && req_s.rready) begin
				rsp_r.rvalid = 1'b0;
			end else if (rd_pend) begin
				if (r_cnt == 0) begin
					rsp_r.rvalid = 1'b1;
					rsp_r.rdata = words[rd_addr[12:2]];
					rd_pend = 1'b0;
				end else r_cnt--;
			end
			if (rsp_s.awready && req_s.awvalid) begin
				wr_addr = req_s.awaddr;
				aw_got = 1'b1;
				aw_cnt = draw_delay();
			end else if (req_s.awvalid && !aw_got) begin
				if (aw_cnt == 0) rsp_r.awready = 1'b1;
				else aw_cnt--;
			end
			if (rsp_s.wready && req_s.wvalid) begin
				wr_data = req_s.wdata;
				wr_strb = req_s.wstrb;
				w_got = 1'b1;
				w_cnt = draw_delay();
			end else if (req_s.wvalid && !w_got) begin
				if (w_cnt == 0) rsp_r.wready = 1'b1;
				else w_cnt--;
			end
			if (rsp_s.bvalid && req_s.bready) begin
				rsp_r.bvalid = 1'b0;
			end else if (aw_got && w_got && !rsp_s.bvalid) begin
				if (b_cnt == 0) begin
					commit_write();
					rsp_r.bvalid = 1'b1;
					aw_got = 1'b0;
					w_got = 1'b0;
					b_cnt = draw_delay();
				end else b_cnt--;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

	localparam logic [31:0] base = 32'h400; // x10 points here
	localparam int cycles_per_instr = 40;

	logic clk = 1'b0;
	logic rstn = 1'b0;
	rv_pkg::axi_req_t bus_req;
	rv_pkg::axi_rsp_t bus_rsp;

	int pc_w = 0;
	int errors = 0;
	int failed_tests = 0;
	int test_errs [1:6];
	string test_names [1:6];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [3:0] exp_strb [$];
	int exp_test [$];

	always #2 clk = ~clk;

	rv_core uut (
		.clk(clk),
		.rstn(rstn),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp)
	);

	tb_axi_mem mem (
		.clk(clk),
		.rstn(rstn),
		.req(bus_req),
		.rsp(bus_rsp)
	);

	bind rv_core rv_core_props props (
		.clk(clk),
		.rstn(rstn),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp)
	);

	function automatic logic [31:0] rtype(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::opc_op};
	endfunction

	function automatic logic [31:0] itype(int imm, int rs1, int f3, int rd, logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] stype(int imm, int rs2, int rs1, int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_pkg::opc_store};
	endfunction

	function automatic logic [31:0] btype(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			rv_pkg::opc_branch};
	endfunction

	function automatic logic [31:0] utype(int imm, int rd, logic [6:0] opc);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] jtype(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::opc_jal};
	endfunction

	task automatic emit(logic [31:0] instr);
		mem.words[pc_w[12:2]] = instr;
		pc_w += 4;
	endtask

	task automatic expect_write(int t, int off, logic [31:0] data, logic [3:0] strb);
		logic [31:0] a;
		a = base + off;
		exp_addr.push_back({a[31:2], 2'b00});
		exp_data.push_back(data);
		exp_strb.push_back(strb);
		exp_test.push_back(t);
	endtask

	task automatic addi(int rd, int rs1, int imm);
		emit(itype(imm, rs1, 0, rd, rv_pkg::opc_op_imm));
	endtask

	task automatic sw_check(int t, int rs2, int off, logic [31:0] data);
		emit(stype(off, rs2, 10, 2));
		expect_write(t, off, data, 4'hf);
	endtask

	task automatic build_program();
		int p;
		addi(10, 0, 'h400);
		addi(1, 0, -7);
		addi(2, 0, 100);
		emit(rtype(0, 2, 1, 0, 3)); // add
		sw_check(2, 3, 0, 32'h5d);
		emit(rtype('h20, 2, 1, 0, 3)); // sub
		sw_check(2, 3, 4, 32'hffffff95);
		emit(itype('h401, 1, 5, 3, rv_pkg::opc_op_imm)); // srai 1
		sw_check(2, 3, 8, 32'hfffffffc);
		emit(itype(28, 1, 5, 3, rv_pkg::opc_op_imm)); // srli 28
		sw_check(2, 3, 12, 32'hf);
		emit(rtype(0, 2, 1, 2, 3));
		sw_check(2, 3, 16, 32'h1);
		emit(rtype(0, 2, 1, 3, 3));
		sw_check(2, 3, 20, 32'h0);
		emit(rtype(0, 2, 1, 4, 3));
		sw_check(2, 3, 24, 32'hffffff9d);
		emit(utype('h12345, 3, rv_pkg::opc_lui));
		sw_check(2, 3, 28, 32'h12345000);
		p = pc_w;
		emit(utype(1, 3, rv_pkg::opc_auipc));
		sw_check(2, 3, 32, p + 'h1000);
		addi(0, 0, 5); // x0 stays zero
		sw_check(2, 0, 36, 32'h0);
		emit(itype(4, 2, 1, 3, rv_pkg::opc_op_imm)); // slli 4
		sw_check(2, 3, 40, 32'h640);
		emit(rtype('h20, 2, 1, 5, 3)); // sra by 100 & 31
		sw_check(2, 3, 44, 32'hffffffff);

		emit(utype('h12345, 5, rv_pkg::opc_lui));
		addi(5, 5, 'h678);
		emit(stype(48, 5, 10, 0)); // sb
		expect_write(3, 48, 32'h00000078, 4'b0001);
		emit(stype(49, 5, 10, 0));
		expect_write(3, 49, 32'h00007800, 4'b0010);
		emit(stype(50, 5, 10, 0));
		expect_write(3, 50, 32'h00780000, 4'b0100);
		emit(stype(51, 5, 10, 0));
		expect_write(3, 51, 32'h78000000, 4'b1000);
		emit(stype(52, 5, 10, 1));
		expect_write(3, 52, 32'h00005678, 4'b0011);
		emit(stype(54, 5, 10, 1));
		expect_write(3, 54, 32'h56780000, 4'b1100);

		addi(6, 0, 'h80);
		sw_check(4, 6, 56, 32'h80);
		emit(itype(56, 10, 0, 7, rv_pkg::opc_load)); // lb
		sw_check(4, 7, 60, 32'hffffff80);
		emit(itype(56, 10, 4, 7, rv_pkg::opc_load)); // lbu
		sw_check(4, 7, 64, 32'h80);
		emit(utype(8, 6, rv_pkg::opc_lui));
		sw_check(4, 6, 68, 32'h8000);
		emit(itype(68, 10, 1, 7, rv_pkg::opc_load)); // lh
		sw_check(4, 7, 72, 32'hffff8000);
		emit(itype(68, 10, 5, 7, rv_pkg::opc_load)); // lhu
		sw_check(4, 7, 76, 32'h8000);

		addi(8, 0, 1);
		emit(btype(8, 0, 0, 0)); // beq taken
		emit(stype(80, 8, 10, 2));
		emit(btype(8, 0, 0, 1)); // bne not taken
		sw_check(5, 8, 84, 32'h1);
		emit(btype(8, 2, 1, 4)); // blt taken
		emit(stype(88, 8, 10, 2));
		emit(btype(8, 2, 1, 6)); // bltu not taken
		sw_check(5, 8, 92, 32'h1);
		emit(btype(8, 1, 2, 5)); // bge taken
		emit(stype(96, 8, 10, 2));
		emit(btype(8, 2, 1, 7)); // bgeu taken
		emit(stype(100, 8, 10, 2));
		p = pc_w;
		emit(jtype(8, 9));
		emit(stype(104, 8, 10, 2));
		sw_check(5, 9, 108, p + 4);
		p = pc_w;
		emit(utype(0, 11, rv_pkg::opc_auipc));
		emit(itype(16, 11, 0, 12, rv_pkg::opc_jalr));
		emit(stype(112, 8, 10, 2));
		emit(stype(112, 8, 10, 2));
		sw_check(5, 12, 116, p + 8);
		addi(13, 0, 'h55);
		sw_check(5, 13, 'h3fc, 32'h55); // last store
		emit(jtype(0, 0)); // spin
	endtask

	task automatic report_test(int t);
		if (test_errs[t] == 0) begin
			$display("test %0d %s: ok", t, test_names[t]);
		end else begin
			$display("test %0d %s: %0d errors", t, test_names[t], test_errs[t]);
			failed_tests++;
		end
		errors += test_errs[t];
	endtask

	initial begin : watchdog
		int limit;
		wait (rstn == 1'b1);
		limit = (pc_w / 4) * cycles_per_instr + 20;
		repeat (limit) @(posedge clk);
		$display("timeout: program did not finish within %0d cycles", limit);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		logic [31:0] got_addr;
		logic [31:0] got_data;
		logic [3:0] got_strb;
		logic [31:0] want_addr;
		logic [31:0] want_data;
		logic [3:0] want_strb;
		int t;
		for (int i = 1; i <= 6; i++) test_errs[i] = 0;
		test_names[1] = "reset and fetch";
		test_names[2] = "arithmetic and logic";
		test_names[3] = "store lanes";
		test_names[4] = "load extension";
		test_names[5] = "control flow";
		test_names[6] = "handshake";
		mem.fill_pattern();
		build_program();
		repeat (4) @(posedge clk);
		#1 rstn = 1'b1;

		assert (!bus_req.arvalid && !bus_req.awvalid && !bus_req.wvalid) else begin
			$display("valid outputs were high right after reset");
			test_errs[1]++;
		end
		// first eight reads are straight-line fetches
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			while (!(bus_req.arvalid && bus_rsp.arready)) @(negedge clk);
			want_addr = rv_pkg::reset_pc + 4 * i;
			assert (bus_req.araddr == want_addr) else begin
				$display("FAIL araddr: got %h expected %h", bus_req.araddr, want_addr);
				test_errs[1]++;
			end
		end
		report_test(1);

		while (exp_test.size() != 0) begin
			@(posedge clk);
			if (mem.wr_addr_q.size() != 0) begin
				got_addr = mem.wr_addr_q.pop_front();
				got_data = mem.wr_data_q.pop_front();
				got_strb = mem.wr_strb_q.pop_front();
				want_addr = exp_addr.pop_front();
				want_data = exp_data.pop_front();
				want_strb = exp_strb.pop_front();
				t = exp_test.pop_front();
				assert (got_addr == want_addr) else begin
					$display("FAIL awaddr: got %h expected %h", got_addr, want_addr);
					test_errs[t]++;
				end
				assert (got_data == want_data) else begin
					$display("FAIL wdata: got %h expected %h", got_data, want_data);
					test_errs[t]++;
				end
				assert (got_strb == want_strb) else begin
					$display("FAIL wstrb: got %h expected %h", got_strb, want_strb);
					test_errs[t]++;
				end
				if (exp_test.size() == 0 || exp_test[0] != t) report_test(t);
			end
		end

		repeat (10) @(posedge clk);
		test_errs[6] = uut.props.fails;
		report_test(6);
		$display("tests run 6, failed %0d, errors %0d", failed_tests, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
